// ==== files.f ====
src/ex_pkg.sv
src/alu.sv
src/branch_compare.sv
src/ex_result_reg.sv
src/ex_stage.sv
tests/ex_checker.sv
tests/ex_stage_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = ex_stage_tb
FILELIST = files.f
FLAGS    = --binary --timing --assert
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;

	import ex_pkg::*;

	localparam int n_rows     = 36;
	localparam int rst_cycles = 8;
	// each row takes at most two cycles, plus reset and drain
	localparam int watchdog_ns = (rst_cycles + 2 * n_rows + 20) * 20;

	typedef struct packed {
		logic [79:0] name;
		word_t       a;
		word_t       b;
		alu_op_t     op;
		br_cond_t    cond;
		logic        stall;  // hold the row one extra cycle
		logic        gap;    // idle cycle after the row
		logic        rnd;    // operands from xorshift
	} row_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        in_valid;
	ex_req_t     in_req;
	logic        stall;
	logic        out_valid;
	ex_resp_t    out_resp;
	logic [79:0] cur_name;
	logic        report;
	int          chk_errors;
	int          chk_done;
	word_t       rnd_state = 32'h08f41a8c;
	row_t        rows [n_rows];

	always #10 clk = ~clk;

	ex_stage dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.stall     (stall),
		.out_valid (out_valid),
		.out_resp  (out_resp)
	);

	ex_checker chk (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.stall      (stall),
		.out_valid  (out_valid),
		.out_resp   (out_resp),
		.test_name  (cur_name),
		.report     (report),
		.errors     (chk_errors),
		.tests_done (chk_done)
	);

	function automatic word_t xorshift(input word_t s);
		word_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// name, a, b, op, cond, stall, gap, rnd
	task automatic fill_table();
		rows[0]  = '{"add_small", 32'h5, 32'h7, op_add, br_none, 1'b0, 1'b0, 1'b0};
		rows[1]  = '{"add_carry", 32'hffffffff, 32'h1, op_add, br_none, 1'b0, 1'b0, 1'b0};
		rows[2]  = '{"sub_noborr", 32'h9, 32'h3, op_sub, br_none, 1'b0, 1'b0, 1'b0};
		rows[3]  = '{"sub_borrow", 32'h3, 32'h9, op_sub, br_none, 1'b0, 1'b0, 1'b0};
		rows[4]  = '{"add_rand", 32'h0, 32'h0, op_add, br_none, 1'b0, 1'b0, 1'b1};
		rows[5]  = '{"sub_rand", 32'h0, 32'h0, op_sub, br_none, 1'b1, 1'b0, 1'b1};
		rows[6]  = '{"and_mix", 32'hf0f000ff, 32'h80000f0f, op_and, br_none, 1'b0, 1'b0, 1'b0};
		rows[7]  = '{"or_mix", 32'hf0f000ff, 32'h80000f0f, op_or, br_none, 1'b0, 1'b0, 1'b0};
		rows[8]  = '{"xor_mix", 32'hf0f000ff, 32'h80000f0f, op_xor, br_none, 1'b0, 1'b0, 1'b0};
		rows[9]  = '{"slt_mix", 32'h80000000, 32'h1, op_slt, br_none, 1'b0, 1'b0, 1'b0};
		rows[10] = '{"sltu_mix", 32'h80000000, 32'h1, op_sltu, br_none, 1'b0, 1'b0, 1'b0};
		rows[11] = '{"sll_0", 32'h12345678, 32'h0, op_sll, br_none, 1'b0, 1'b0, 1'b0};
		rows[12] = '{"sll_31", 32'h3, 32'h1f, op_sll, br_none, 1'b0, 1'b0, 1'b0};
		rows[13] = '{"srl_hi", 32'h80000000, 32'hffffffe4, op_srl, br_none, 1'b0, 1'b0, 1'b0};
		rows[14] = '{"sra_neg", 32'h80000000, 32'h1f, op_sra, br_none, 1'b0, 1'b1, 1'b0};
		rows[15] = '{"sra_hi", 32'hf0000000, 32'hffffff04, op_sra, br_none, 1'b0, 1'b0, 1'b0};
		rows[16] = '{"br_eq_t", 32'h7, 32'h7, op_branch, br_eq, 1'b0, 1'b0, 1'b0};
		rows[17] = '{"br_ne_f", 32'h7, 32'h7, op_branch, br_ne, 1'b0, 1'b0, 1'b0};
		rows[18] = '{"br_ltz_n", 32'hffffffff, 32'h0, op_branch, br_ltz, 1'b0, 1'b0, 1'b0};
		rows[19] = '{"br_gtz_z", 32'h0, 32'h3, op_branch, br_gtz, 1'b0, 1'b0, 1'b0};
		rows[20] = '{"br_gtz_p", 32'h5, 32'h3, op_branch, br_gtz, 1'b0, 1'b0, 1'b0};
		rows[21] = '{"br_lez_z", 32'h0, 32'h0, op_branch, br_lez, 1'b0, 1'b0, 1'b0};
		rows[22] = '{"br_gez_n", 32'hfffffffc, 32'h1, op_branch, br_gez, 1'b0, 1'b0, 1'b0};
		rows[23] = '{"br_none", 32'h1, 32'h1, op_branch, br_none, 1'b0, 1'b0, 1'b0};
		rows[24] = '{"add_eq", 32'h7, 32'h7, op_add, br_eq, 1'b0, 1'b0, 1'b0};
		rows[25] = '{"mult_rsv", 32'h6, 32'h7, op_mult, br_none, 1'b0, 1'b0, 1'b0};
		rows[26] = '{"divu_rsv", 32'h40, 32'h2, op_divu, br_none, 1'b1, 1'b0, 1'b0};
		rows[27] = '{"rand_br", 32'h0, 32'h0, op_branch, br_ne, 1'b0, 1'b0, 1'b1};
		rows[28] = '{"br_eq_f", 32'h7, 32'h8, op_branch, br_eq, 1'b0, 1'b0, 1'b0};
		rows[29] = '{"br_ltz_z", 32'h0, 32'h4, op_branch, br_ltz, 1'b0, 1'b0, 1'b0};
		rows[30] = '{"br_ltz_p", 32'h5, 32'h5, op_branch, br_ltz, 1'b0, 1'b0, 1'b0};
		rows[31] = '{"br_gtz_n", 32'hfffffff0, 32'h2, op_branch, br_gtz, 1'b0, 1'b0, 1'b0};
		rows[32] = '{"br_lez_n", 32'h80000000, 32'h0, op_branch, br_lez, 1'b0, 1'b0, 1'b0};
		rows[33] = '{"br_lez_p", 32'h1, 32'h9, op_branch, br_lez, 1'b0, 1'b0, 1'b0};
		rows[34] = '{"br_gez_z", 32'h0, 32'h6, op_branch, br_gez, 1'b0, 1'b0, 1'b0};
		rows[35] = '{"br_gez_p", 32'h7fffffff, 32'h1, op_branch, br_gez, 1'b0, 1'b0, 1'b0};
	endtask

	task automatic apply_row(input row_t r);
		word_t a;
		word_t b;
		a = r.a;
		b = r.b;
		if (r.rnd) begin
			rnd_state = xorshift(rnd_state);
			a = rnd_state;
			rnd_state = xorshift(rnd_state);
			b = rnd_state;
		end
		@(posedge clk);
		in_valid <= 1'b1;
		in_req   <= '{a: a, b: b, op: r.op, cond: r.cond};
		cur_name <= r.name;
		stall    <= r.stall;
		if (r.stall) begin
			@(posedge clk);
			stall <= 1'b0; // accepted at the following edge
		end
		if (r.gap) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		stall = 1'b0;
		cur_name = '0;
		report = 1'b0;
		fill_table();
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(rows[i]);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		repeat (3) @(posedge clk);
		report <= 1'b1;
		@(posedge clk); // checker prints its summary at this edge
		#1;
		if (chk_errors == 0 && chk_done == n_rows) begin
			$display("*** TEST PASSED ***");
		end else begin
			if (chk_done != n_rows) begin
				$display("only %0d of %0d tests produced a result", chk_done, n_rows);
			end
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== tests/ex_checker.sv ====
`timescale 1ns/1ps

module ex_checker (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  ex_pkg::ex_req_t  in_req,
	input  logic             stall,
	input  logic             out_valid,
	input  ex_pkg::ex_resp_t out_resp,
	input  logic [79:0]      test_name,
	input  logic             report,
	output int               errors,
	output int               tests_done
);

	import ex_pkg::*;

	logic        exp_valid;  // what out_valid should show now
	logic        exp_new;    // output holds an item not yet compared
	ex_resp_t    exp_resp;
	logic [79:0] exp_name;
	int          passes;
	logic        reported;   // summary already printed

	// reference model built from the result rules
	function automatic ex_resp_t expect_resp(input ex_req_t r);
		ex_resp_t           e;
		logic [32:0]        wide;
		logic signed [31:0] sa;
		e = '0;
		sa = r.a;
		case (r.op)
			op_add: begin
				wide = {1'b0, r.a} + {1'b0, r.b};
				e.result = wide[31:0];
				e.carry = wide[32];
			end
			op_sub: begin
				e.result = r.a - r.b;
				e.carry = (r.a >= r.b); // set when nothing is borrowed
			end
			op_and: e.result = r.a & r.b;
			op_or: e.result = r.a | r.b;
			op_xor: e.result = r.a ^ r.b;
			op_slt: e.result = {31'd0, sa < $signed(r.b)};
			op_sltu: e.result = {31'd0, r.a < r.b};
			op_sll: e.result = r.a << r.b[4:0];
			op_srl: e.result = r.a >> r.b[4:0];
			op_sra: e.result = sa >>> r.b[4:0];
			default: e.result = '0;
		endcase
		e.zero = (e.result == '0);
		if (r.op == op_branch) begin
			case (r.cond)
				br_eq: e.taken = (r.a == r.b);
				br_ne: e.taken = (r.a != r.b);
				br_ltz: e.taken = (sa < 0);
				br_gtz: e.taken = (sa > 0);
				br_lez: e.taken = (sa <= 0);
				br_gez: e.taken = (sa >= 0);
				default: e.taken = 1'b0;
			endcase
		end
		return e;
	endfunction

	initial begin
		errors = 0;
		tests_done = 0;
		passes = 0;
		exp_valid = 1'b0;
		exp_new = 1'b0;
		exp_resp = '0;
		exp_name = '0;
		reported = 1'b0;
	end

	always @(posedge clk) begin
		if (rst) begin
			exp_valid = 1'b0;
			exp_new = 1'b0;
		end else begin
			if (out_valid !== exp_valid) begin
				errors++;
				$display("out_valid is %b but %b was expected at %0t ns",
					out_valid, exp_valid, $time);
			end
			if (exp_new && out_valid === 1'b1) begin
				tests_done++;
				if (out_resp === exp_resp) begin
					passes++;
					$display("pass %0s: result %h zero %b carry %b taken %b", exp_name,
						out_resp.result, out_resp.zero, out_resp.carry, out_resp.taken);
				end else begin
					errors++;
					$display("** Error %0s: expected result %h zero %b carry %b taken %b",
						exp_name, exp_resp.result, exp_resp.zero, exp_resp.carry,
						exp_resp.taken);
					$display("** Error %0s: actual   result %h zero %b carry %b taken %b",
						exp_name, out_resp.result, out_resp.zero, out_resp.carry,
						out_resp.taken);
				end
				exp_new = 1'b0;
			end else if (exp_valid && out_resp !== exp_resp) begin
				errors++;
				$display("output of %0s changed while it should have been held", exp_name);
			end
			if (!stall) begin
				exp_valid = in_valid;
				if (in_valid) begin
					exp_resp = expect_resp(in_req);
					exp_name = test_name;
					exp_new = 1'b1;
				end
			end
		end
		// closing summary once the testbench asks for it
		if (report && !reported) begin
			reported = 1'b1;
			if (exp_new) begin
				errors++;
				$display("no output was seen for %0s", exp_name);
			end
			$display("tests checked %0d, passed %0d, errors %0d", tests_done, passes, errors);
		end
	end

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  ex_pkg::ex_req_t  in_req,
	input  logic             stall,
	output logic             out_valid,
	output ex_pkg::ex_resp_t out_resp
);

	import ex_pkg::*;

	word_t alu_result;
	logic  alu_carry;
	logic  cond_true;

	// both units see the same operands in the same cycle
	alu u_alu (
		.a      (in_req.a),
		.b      (in_req.b),
		.op     (in_req.op),
		.result (alu_result),
		.carry  (alu_carry)
	);

	branch_compare u_branch_compare (
		.a         (in_req.a),
		.b         (in_req.b),
		.cond      (in_req.cond),
		.cond_true (cond_true)
	);

	// joins the two answers into the stage register
	ex_result_reg u_ex_result_reg (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.in_valid   (in_valid),
		.op         (in_req.op),
		.alu_result (alu_result),
		.alu_carry  (alu_carry),
		.cond_true  (cond_true),
		.out_valid  (out_valid),
		.out_resp   (out_resp)
	);

endmodule

// ==== src/ex_result_reg.sv ====
`timescale 1ns/1ps

module ex_result_reg (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             in_valid,
	input  ex_pkg::alu_op_t  op,
	input  ex_pkg::word_t    alu_result,
	input  logic             alu_carry,
	input  logic             cond_true,
	output logic             out_valid,
	output ex_pkg::ex_resp_t out_resp
);

	import ex_pkg::*;

	logic     accept;
	ex_resp_t next_resp;
	alu_op_t  op_q;      // op of the item now in out_resp

	assign accept = in_valid && !stall;

	// taken only counts for branch ops
	always_comb begin
		next_resp.result = alu_result;
		next_resp.zero   = (alu_result == '0);
		next_resp.carry  = alu_carry;
		next_resp.taken  = cond_true && (op == op_branch);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_resp  <= '0;
		end else if (!stall) begin
			out_valid <= in_valid; // empty cycle drops valid
			if (in_valid) begin
				out_resp <= next_resp;
			end
		end
	end

	// kept only so the carry check below can see the op
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= op;
		end
	end

	// nothing comes out in the first cycle after reset
	assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid set right after reset");

	// a stalled edge must leave the whole output alone
	assert property (@(posedge clk) disable iff (rst)
		stall |=> ($stable(out_valid) && $stable(out_resp)))
		else $error("output changed across a stall");

	// alu only reports carry for add and sub
	assert property (@(posedge clk) disable iff (rst)
		out_resp.carry |-> (op_q inside {op_add, op_sub}))
		else $error("carry set for op %0d", op_q);

endmodule

// ==== src/branch_compare.sv ====
`timescale 1ns/1ps

module branch_compare (
	input  ex_pkg::word_t    a,
	input  ex_pkg::word_t    b,
	input  ex_pkg::br_cond_t cond,
	output logic             cond_true
);

	import ex_pkg::*;

	logic ops_equal;
	logic a_neg;   // sign bit of a
	logic a_zero;

	// shared compare terms
	assign ops_equal = (a == b);
	assign a_neg     = a[31];
	assign a_zero    = (a == '0);

	always_comb begin
		case (cond)
			br_eq: begin
				cond_true = ops_equal;
			end
			br_ne: begin
				cond_true = !ops_equal;
			end
			br_ltz: begin
				cond_true = a_neg;
			end
			br_gtz: begin
				cond_true = !a_neg && !a_zero; // strictly positive
			end
			br_lez: begin
				cond_true = a_neg || a_zero;
			end
			br_gez: begin
				cond_true = !a_neg;
			end
			default: begin
				// br_none and the spare code never branch
				cond_true = 1'b0;
			end
		endcase
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  ex_pkg::word_t   a,
	input  ex_pkg::word_t   b,
	input  ex_pkg::alu_op_t op,
	output ex_pkg::word_t   result,
	output logic            carry
);

	import ex_pkg::*;

	logic    is_sub;
	logic    is_arith;
	word_t   adder_b;      // b or its inverse for sub
	logic [32:0] sum;      // extra bit holds the carry out
	word_t   bitwise_and;
	word_t   bitwise_or;
	word_t   bitwise_xor;
	word_t   less_signed;
	word_t   less_unsigned;
	shamt_t  shamt;
	word_t   shift_ll;
	word_t   shift_rl;
	word_t   shift_ra;

	assign is_sub   = (op == op_sub);
	assign is_arith = (op == op_add) || (op == op_sub);

	// one adder serves both add and sub
	// sub is a + ~b + 1, the +1 enters as carry in
	assign adder_b = is_sub ? ~b : b;
	assign sum     = {1'b0, a} + {1'b0, adder_b} + {32'd0, is_sub};

	assign bitwise_and = a & b;
	assign bitwise_or  = a | b;
	assign bitwise_xor = a ^ b;

	assign less_signed   = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	assign less_unsigned = (a < b) ? 32'd1 : 32'd0;

	// only the low five bits of b count
	assign shamt    = b[4:0];
	assign shift_ll = a << shamt;
	assign shift_rl = a >> shamt;
	assign shift_ra = word_t'($signed(a) >>> shamt); // sign fill

	always_comb begin
		case (op)
			op_add: begin
				result = sum[31:0];
			end
			op_sub: begin
				result = sum[31:0];
			end
			op_and: begin
				result = bitwise_and;
			end
			op_or: begin
				result = bitwise_or;
			end
			op_xor: begin
				result = bitwise_xor;
			end
			op_slt: begin
				result = less_signed;
			end
			op_sltu: begin
				result = less_unsigned;
			end
			op_sll: begin
				result = shift_ll;
			end
			op_srl: begin
				result = shift_rl;
			end
			op_sra: begin
				result = shift_ra;
			end
			op_branch: begin
				result = '0; // branch outcome comes from branch_compare
			end
			default: begin
				// mult/div codes and code 15 are not implemented
				result = '0;
			end
		endcase
	end

	// for sub a set carry means no borrow
	assign carry = is_arith ? sum[32] : 1'b0;

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

	// the word width is fixed by the instruction set
	localparam int word_w  = 32;
	localparam int shamt_w = 5;

	typedef logic [word_w-1:0]  word_t;   // operands and results
	typedef logic [shamt_w-1:0] shamt_t;  // low bits of b for shifts

	// alu operation codes as decoded by the previous stage
	typedef enum logic [3:0] {
		op_add    = 4'd0,
		op_sub    = 4'd1,
		op_and    = 4'd2,
		op_or     = 4'd3,
		op_xor    = 4'd4,
		op_slt    = 4'd5,
		op_sltu   = 4'd6,
		op_sll    = 4'd7,
		op_srl    = 4'd8,
		op_sra    = 4'd9,
		op_mult   = 4'd10, // reserved
		op_multu  = 4'd11, // reserved
		op_div    = 4'd12, // reserved
		op_divu   = 4'd13, // reserved
		op_branch = 4'd14
	} alu_op_t;

	// branch conditions, code 7 is unused and acts as br_none
	typedef enum logic [2:0] {
		br_none = 3'd0,
		br_eq   = 3'd1,
		br_ne   = 3'd2,
		br_ltz  = 3'd3,
		br_gtz  = 3'd4,
		br_lez  = 3'd5,
		br_gez  = 3'd6
	} br_cond_t;

	// request from the decode stage
	typedef struct packed {
		word_t    a;
		word_t    b;
		alu_op_t  op;
		br_cond_t cond;
	} ex_req_t;

	// registered response towards memory stage
	typedef struct packed {
		word_t result;
		logic  zero;
		logic  carry;
		logic  taken;
	} ex_resp_t;

endpackage
